// ==== logic/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // Data port command, one bit as the core drives it
    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } mem_cmd_e;

    // Access width, same code as the core's dmem_width
    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'b00,
        WIDTH_HALF = 2'b01,
        WIDTH_WORD = 2'b10
    } mem_width_e;

    // Shared by the fetch and data bridges.
    // IDLE waits for req, BUS holds cyc until ack, RESP is the one-cycle resp pulse
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_BUS  = 2'b01,
        ST_RESP = 2'b10
    } bridge_state_e;

endpackage : bus_pkg

`default_nettype wire

// ==== logic/fetch_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_bridge import bus_pkg::*; (
    input  logic        clk_core,
    input  logic        rst_n_i,

    // Instruction port of the core
    input  logic        imem_req_i,
    input  logic [31:0] imem_addr_i,
    output logic [31:0] imem_rdata_o,
    output logic        imem_resp_o,

    // Read-only bus master
    output logic        wb_cyc_o,
    output logic [29:0] wb_adr_o,
    input  logic        wb_ack_i,
    input  logic [31:0] wb_dat_i
);

    bridge_state_e state_q;
    logic [31:0]   rdata_q;

    always_ff @(posedge clk_core or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (imem_req_i) begin
                        state_q <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (wb_ack_i) begin
                        state_q <= ST_RESP;
                    end
                end
                ST_RESP: state_q <= ST_IDLE; // req is still high here, ignored
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Registered copy of the bus data, handed back with resp
    always_ff @(posedge clk_core) begin
        if (state_q == ST_BUS && wb_ack_i) begin
            rdata_q <= wb_dat_i;
        end
    end

    assign wb_cyc_o     = (state_q == ST_BUS);
    assign wb_adr_o     = imem_addr_i[31:2];  // Core holds addr until resp
    assign imem_resp_o  = (state_q == ST_RESP);
    assign imem_rdata_o = rdata_q;

endmodule : fetch_bridge

`default_nettype wire

// ==== logic/data_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_bridge import bus_pkg::*; (
    input  logic        clk_core,
    input  logic        rst_n_i,

    // Data port of the core
    input  logic        dmem_req_i,
    input  mem_cmd_e    dmem_cmd_i,
    input  mem_width_e  dmem_width_i,
    input  logic [31:0] dmem_addr_i,
    input  logic [31:0] dmem_wdata_i,
    output logic [31:0] dmem_rdata_o,
    output logic        dmem_resp_o,
    output logic        dmem_err_o,

    // Bus master
    output logic        wb_cyc_o,
    output logic        wb_we_o,
    output logic [29:0] wb_adr_o,
    output logic [3:0]  wb_sel_o,
    output logic [31:0] wb_dat_o,
    input  logic        wb_ack_i,
    input  logic [31:0] wb_dat_i
);

    bridge_state_e state_q;
    logic          err_q;
    logic [31:0]   rdata_q;
    logic          misaligned;
    logic [3:0]    sel_d;
    logic [31:0]   wdata_lanes;
    logic [4:0]    lane_shift;
    logic [31:0]   rd_shifted;
    logic [31:0]   rd_ext;

    // Byte lanes, write replication and alignment check
    always_comb begin
        sel_d       = 4'b1111;
        wdata_lanes = dmem_wdata_i;
        misaligned  = 1'b0;
        case (dmem_width_i)
            WIDTH_BYTE: begin
                sel_d       = 4'b0001 << dmem_addr_i[1:0];
                wdata_lanes = {4{dmem_wdata_i[7:0]}};
            end
            WIDTH_HALF: begin
                sel_d       = 4'b0011 << dmem_addr_i[1:0];
                wdata_lanes = {2{dmem_wdata_i[15:0]}};
                misaligned  = dmem_addr_i[0];
            end
            WIDTH_WORD: misaligned = |dmem_addr_i[1:0];
            default:    misaligned = 1'b1;  // Reserved width code
        endcase
    end

    // Move the addressed lanes down to bit 0, then zero-extend
    assign lane_shift = {dmem_addr_i[1:0], 3'b000};
    assign rd_shifted = wb_dat_i >> lane_shift;

    always_comb begin
        case (dmem_width_i)
            WIDTH_BYTE: rd_ext = {24'h0, rd_shifted[7:0]};
            WIDTH_HALF: rd_ext = {16'h0, rd_shifted[15:0]};
            default:    rd_ext = rd_shifted;
        endcase
    end

    always_ff @(posedge clk_core or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (dmem_req_i && misaligned) begin
                        state_q <= ST_RESP;  // No bus cycle at all
                        err_q   <= 1'b1;
                    end else if (dmem_req_i) begin
                        state_q <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (wb_ack_i) begin
                        state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    state_q <= ST_IDLE;
                    err_q   <= 1'b0;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_core) begin
        if (state_q == ST_IDLE && dmem_req_i && misaligned) begin
            rdata_q <= '0;
        end else if (state_q == ST_BUS && wb_ack_i) begin
            rdata_q <= rd_ext;
        end
    end

    assign wb_cyc_o     = (state_q == ST_BUS);
    assign wb_we_o      = wb_cyc_o && (dmem_cmd_i == CMD_WRITE);
    assign wb_adr_o     = dmem_addr_i[31:2];
    assign wb_sel_o     = sel_d;
    assign wb_dat_o     = wdata_lanes;
    assign dmem_resp_o  = (state_q == ST_RESP);
    assign dmem_err_o   = err_q;
    assign dmem_rdata_o = rdata_q;

endmodule : data_bridge

`default_nettype wire

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic        clk_core,
    input  logic        rst_n_i,

    // Fetch master, read only
    input  logic        f_cyc_i,
    input  logic [29:0] f_adr_i,
    output logic        f_ack_o,
    output logic [31:0] f_dat_o,

    // Data master
    input  logic        d_cyc_i,
    input  logic        d_we_i,
    input  logic [29:0] d_adr_i,
    input  logic [3:0]  d_sel_i,
    input  logic [31:0] d_dat_i,
    output logic        d_ack_o,
    output logic [31:0] d_dat_o,

    // Memory port
    output logic        m_stb_o,
    output logic        m_we_o,
    output logic [29:0] m_adr_o,
    output logic [3:0]  m_sel_o,
    output logic [31:0] m_dat_o,
    input  logic        m_ack_i,
    input  logic [31:0] m_dat_i
);

    logic locked_q;     // A cycle is running for the last-served master
    logic last_data_q;  // 1 when the data master was served last
    logic hold;
    logic gnt_data;

    // Owner keeps the bus until its cyc drops
    assign hold = locked_q && (last_data_q ? d_cyc_i : f_cyc_i);

    always_comb begin
        if (hold) begin
            gnt_data = last_data_q;
        end else if (f_cyc_i && d_cyc_i) begin
            gnt_data = !last_data_q;  // Tie goes to the other master
        end else begin
            gnt_data = d_cyc_i;
        end
    end

    always_ff @(posedge clk_core or negedge rst_n_i) begin
        if (!rst_n_i) begin
            locked_q    <= 1'b0;
            last_data_q <= 1'b1;
        end else begin
            locked_q <= m_stb_o;
            if (m_stb_o) begin
                last_data_q <= gnt_data;
            end
        end
    end

    assign m_stb_o = gnt_data ? d_cyc_i : f_cyc_i;
    assign m_we_o  = gnt_data && d_we_i;
    assign m_adr_o = gnt_data ? d_adr_i : f_adr_i;
    assign m_sel_o = gnt_data ? d_sel_i : 4'b1111;  // Fetch reads all lanes
    assign m_dat_o = gnt_data ? d_dat_i : 32'h0;

    // Response goes back to the owner only
    assign f_ack_o = m_ack_i && !gnt_data;
    assign d_ack_o = m_ack_i && gnt_data;
    assign f_dat_o = gnt_data ? 32'h0 : m_dat_i;
    assign d_dat_o = gnt_data ? m_dat_i : 32'h0;

endmodule : bus_arbiter

`default_nettype wire

// ==== logic/word_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_memory #(
    parameter int MEM_WORDS   = 256,  // Power of two
    parameter int WAIT_STATES = 1
) (
    input  logic        clk_core,
    input  logic        rst_n_i,

    input  logic        stb_i,
    input  logic        we_i,
    input  logic [29:0] adr_i,
    input  logic [3:0]  sel_i,
    input  logic [31:0] dat_i,
    output logic        ack_o,
    output logic [31:0] dat_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [31:0]      mem [MEM_WORDS];
    logic [CNT_W-1:0] wait_cnt_q;
    logic [IDX_W-1:0] idx;
    logic             access;

    assign idx = adr_i[IDX_W-1:0];  // Upper address bits wrap

    // Access happens at the edge that raises ack
    assign access = stb_i && !ack_o && (wait_cnt_q == CNT_W'(WAIT_STATES));

    always_ff @(posedge clk_core or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o      <= 1'b0;
            wait_cnt_q <= '0;
        end else begin
            ack_o <= access;  // Single-cycle pulse
            if (access || !stb_i) begin
                wait_cnt_q <= '0;
            end else if (!ack_o) begin
                wait_cnt_q <= wait_cnt_q + 1'b1;
            end
        end
    end

    // Contents start at zero; writes touch only the selected lanes
    always_ff @(posedge clk_core or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (access && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (sel_i[b]) begin
                    mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (access) begin
            dat_o <= mem[idx];
        end
    end

endmodule : word_memory

`default_nettype wire

// ==== logic/mem_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top import bus_pkg::*; #(
    parameter int MEM_WORDS   = 256,
    parameter int WAIT_STATES = 1
) (
    input  logic        clk_core,
    input  logic        rst_n_i,

    // Instruction port
    input  logic        imem_req_i,
    input  logic [31:0] imem_addr_i,
    output logic [31:0] imem_rdata_o,
    output logic        imem_resp_o,

    // Data port
    input  logic        dmem_req_i,
    input  mem_cmd_e    dmem_cmd_i,
    input  mem_width_e  dmem_width_i,
    input  logic [31:0] dmem_addr_i,
    input  logic [31:0] dmem_wdata_i,
    output logic [31:0] dmem_rdata_o,
    output logic        dmem_resp_o,
    output logic        dmem_err_o
);

    // Fetch master bus
    logic        f_cyc;
    logic [29:0] f_adr;
    logic        f_ack;
    logic [31:0] f_rdat;

    // Data master bus
    logic        d_cyc;
    logic        d_we;
    logic [29:0] d_adr;
    logic [3:0]  d_sel;
    logic [31:0] d_wdat;
    logic        d_ack;
    logic [31:0] d_rdat;

    // Arbiter to memory
    logic        m_stb;
    logic        m_we;
    logic [29:0] m_adr;
    logic [3:0]  m_sel;
    logic [31:0] m_wdat;
    logic        m_ack;
    logic [31:0] m_rdat;

    fetch_bridge fetch_bridge_inst (
        .clk_core     (clk_core),
        .rst_n_i      (rst_n_i),
        .imem_req_i   (imem_req_i),
        .imem_addr_i  (imem_addr_i),
        .imem_rdata_o (imem_rdata_o),
        .imem_resp_o  (imem_resp_o),
        .wb_cyc_o     (f_cyc),
        .wb_adr_o     (f_adr),
        .wb_ack_i     (f_ack),
        .wb_dat_i     (f_rdat)
    );

    data_bridge data_bridge_inst (
        .clk_core     (clk_core),
        .rst_n_i      (rst_n_i),
        .dmem_req_i   (dmem_req_i),
        .dmem_cmd_i   (dmem_cmd_i),
        .dmem_width_i (dmem_width_i),
        .dmem_addr_i  (dmem_addr_i),
        .dmem_wdata_i (dmem_wdata_i),
        .dmem_rdata_o (dmem_rdata_o),
        .dmem_resp_o  (dmem_resp_o),
        .dmem_err_o   (dmem_err_o),
        .wb_cyc_o     (d_cyc),
        .wb_we_o      (d_we),
        .wb_adr_o     (d_adr),
        .wb_sel_o     (d_sel),
        .wb_dat_o     (d_wdat),
        .wb_ack_i     (d_ack),
        .wb_dat_i     (d_rdat)
    );

    bus_arbiter bus_arbiter_inst (
        .clk_core (clk_core),
        .rst_n_i  (rst_n_i),
        .f_cyc_i  (f_cyc),
        .f_adr_i  (f_adr),
        .f_ack_o  (f_ack),
        .f_dat_o  (f_rdat),
        .d_cyc_i  (d_cyc),
        .d_we_i   (d_we),
        .d_adr_i  (d_adr),
        .d_sel_i  (d_sel),
        .d_dat_i  (d_wdat),
        .d_ack_o  (d_ack),
        .d_dat_o  (d_rdat),
        .m_stb_o  (m_stb),
        .m_we_o   (m_we),
        .m_adr_o  (m_adr),
        .m_sel_o  (m_sel),
        .m_dat_o  (m_wdat),
        .m_ack_i  (m_ack),
        .m_dat_i  (m_rdat)
    );

    word_memory #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) word_memory_inst (
        .clk_core (clk_core),
        .rst_n_i  (rst_n_i),
        .stb_i    (m_stb),
        .we_i     (m_we),
        .adr_i    (m_adr),
        .sel_i    (m_sel),
        .dat_i    (m_wdat),
        .ack_o    (m_ack),
        .dat_o    (m_rdat)
    );

endmodule : mem_subsystem_top

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_core_o,
    output logic rst_n_o
);

    initial begin
        clk_core_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_core_o = ~clk_core_o;
        end
    end

    // Reset released on a rising edge, like any other stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_core_o);
        rst_n_o <= 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== tb/mem_subsystem_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_asserts (
    input logic        clk_core,
    input logic        rst_n_i,
    input logic        cyc_i,    // Master cycle and the ack it sees
    input logic [29:0] adr_i,
    input logic        ack_i,
    input logic        resp_i,   // Core-side response, tied low where absent
    input logic        err_i,
    input logic        ack_a_i,  // Both arbiter acks
    input logic        ack_b_i
);

    // Master holds cyc and address until the slave acknowledges
    cyc_held: assert property (@(posedge clk_core) disable iff (!rst_n_i)
        cyc_i && !ack_i |=> cyc_i && $stable(adr_i))
        else $error("bus cycle dropped or address changed before ack");

    resp_pulse: assert property (@(posedge clk_core) disable iff (!rst_n_i)
        resp_i |=> !resp_i)
        else $error("core response held longer than one cycle");

    err_with_resp: assert property (@(posedge clk_core) disable iff (!rst_n_i)
        err_i |-> resp_i)
        else $error("error flag raised without a response");

    single_ack: assert property (@(posedge clk_core) disable iff (!rst_n_i)
        !(ack_a_i && ack_b_i))
        else $error("arbiter acknowledged both masters in one cycle");

endmodule : mem_subsystem_asserts

bind data_bridge mem_subsystem_asserts data_bridge_sva (
    .clk_core (clk_core),
    .rst_n_i  (rst_n_i),
    .cyc_i    (wb_cyc_o),
    .adr_i    (wb_adr_o),
    .ack_i    (wb_ack_i),
    .resp_i   (dmem_resp_o),
    .err_i    (dmem_err_o),
    .ack_a_i  (1'b0),
    .ack_b_i  (1'b0)
);

// Fetch master protocol is watched from the arbiter side
bind bus_arbiter mem_subsystem_asserts bus_arbiter_sva (
    .clk_core (clk_core),
    .rst_n_i  (rst_n_i),
    .cyc_i    (f_cyc_i),
    .adr_i    (f_adr_i),
    .ack_i    (f_ack_o),
    .resp_i   (1'b0),
    .err_i    (1'b0),
    .ack_a_i  (f_ack_o),
    .ack_b_i  (d_ack_o)
);

`default_nettype wire

// ==== tb/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb import bus_pkg::*; ();

    localparam int MEM_WORDS        = 256;
    localparam int WAIT_STATES      = 1;
    localparam int MEM_BYTES        = MEM_WORDS * 4;
    localparam int RESET_CYCLES     = 10;
    localparam int WORD_TESTS       = 16;
    localparam int LANE_TESTS       = 24;
    localparam int MISALIGNED_TESTS = 8;
    localparam int FETCH_TESTS      = 16;
    localparam int MIXED_TESTS      = 40;
    // Every transaction of every phase, both ports counted
    localparam int NUM_TRANS = 2 * WORD_TESTS + 2 * LANE_TESTS + 2 * MISALIGNED_TESTS
                             + FETCH_TESTS + 2 * MIXED_TESTS;
    localparam int TIMEOUT_CYCLES = NUM_TRANS * (2 * (WAIT_STATES + 3) + 4) + RESET_CYCLES;
    localparam logic [31:0] BYTE_MASK   = 32'(MEM_BYTES) - 32'd1;
    localparam logic [31:0] WINDOW_MASK = ~(32'(MEM_BYTES) - 32'd64);  // Hot 64-byte window

    logic        clk_core;
    logic        rst_n;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        imem_resp;
    logic        dmem_req;
    mem_cmd_e    dmem_cmd;
    mem_width_e  dmem_width;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_resp;
    logic        dmem_err;

    logic [7:0]  model_mem [MEM_BYTES];  // Byte image of the memory
    logic [31:0] written_q [$];
    logic [31:0] rng;
    int          errors;
    int          cycle_cnt;
    int          imem_resp_cnt;
    int          dmem_resp_cnt;
    int          fetch_issued;
    int          data_issued;
    bit          f_pending;
    bit          d_pending;

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (RESET_CYCLES)
    ) tb_clock_gen_inst (
        .clk_core_o (clk_core),
        .rst_n_o    (rst_n)
    );

    mem_subsystem_top #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) mem_subsystem_top_inst (
        .clk_core     (clk_core),
        .rst_n_i      (rst_n),
        .imem_req_i   (imem_req),
        .imem_addr_i  (imem_addr),
        .imem_rdata_o (imem_rdata),
        .imem_resp_o  (imem_resp),
        .dmem_req_i   (dmem_req),
        .dmem_cmd_i   (dmem_cmd),
        .dmem_width_i (dmem_width),
        .dmem_addr_i  (dmem_addr),
        .dmem_wdata_i (dmem_wdata),
        .dmem_rdata_o (dmem_rdata),
        .dmem_resp_o  (dmem_resp),
        .dmem_err_o   (dmem_err)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic mem_width_e pick_width(input logic [31:0] r);
        mem_width_e w;
        case (r % 32'd3)
            32'd0:   w = WIDTH_BYTE;
            32'd1:   w = WIDTH_HALF;
            default: w = WIDTH_WORD;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] align_addr(input logic [31:0] addr, input mem_width_e width);
        logic [31:0] a;
        a = addr;
        if (width == WIDTH_HALF) begin
            a[0] = 1'b0;
        end else if (width == WIDTH_WORD) begin
            a[1:0] = 2'b00;
        end
        return a;
    endfunction

    function automatic logic is_misaligned(input logic [31:0] addr, input mem_width_e width);
        return (width == WIDTH_HALF && addr[0]) || (width == WIDTH_WORD && addr[1:0] != 2'b00);
    endfunction

    // Little-endian read, zero-extended; addresses wrap over the byte image
    function automatic logic [31:0] model_read(input logic [31:0] addr, input mem_width_e width);
        logic [31:0] val;
        int          base;
        base = int'(addr & BYTE_MASK);
        case (width)
            WIDTH_BYTE: val = {24'h0, model_mem[base]};
            WIDTH_HALF: val = {16'h0, model_mem[base + 1], model_mem[base]};
            default:    val = {model_mem[base + 3], model_mem[base + 2],
                               model_mem[base + 1], model_mem[base]};
        endcase
        return val;
    endfunction

    task automatic model_write(input logic [31:0] addr, input mem_width_e width,
                               input logic [31:0] wdata);
        int base;
        int nbytes;
        base   = int'(addr & BYTE_MASK);
        nbytes = (width == WIDTH_BYTE) ? 1 : ((width == WIDTH_HALF) ? 2 : 4);
        for (int i = 0; i < nbytes; i++) begin
            model_mem[base + i] = wdata[8*i +: 8];
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Error at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
        errors++;
    endtask

    // One data request; timed ones also check the uncontended latency
    task automatic data_transfer(input mem_cmd_e cmd, input mem_width_e width,
                                 input logic [31:0] addr, input logic [31:0] wdata,
                                 input bit timed);
        logic        exp_err;
        logic [31:0] exp_rdata;
        int          waited;
        @(posedge clk_core);
        dmem_req   <= 1'b1;
        dmem_cmd   <= cmd;
        dmem_width <= width;
        dmem_addr  <= addr;
        dmem_wdata <= wdata;
        d_pending = 1'b1;
        data_issued++;
        waited = 0;
        do begin
            @(negedge clk_core);
            waited++;
        end while (!dmem_resp);
        exp_err   = is_misaligned(addr, width);
        exp_rdata = exp_err ? 32'h0 : model_read(addr, width);
        if (dmem_err !== exp_err) begin
            report_mismatch("dmem_err_o", {31'h0, exp_err}, {31'h0, dmem_err});
        end
        if ((cmd == CMD_READ || exp_err) && dmem_rdata !== exp_rdata) begin
            report_mismatch("dmem_rdata_o", exp_rdata, dmem_rdata);
        end
        if (timed && waited - 1 != (exp_err ? 1 : WAIT_STATES + 3)) begin
            report_mismatch("dmem_resp_o latency", exp_err ? 32'd1 : 32'(WAIT_STATES + 3),
                            32'(waited - 1));
        end
        if (cmd == CMD_WRITE && !exp_err) begin
            model_write(addr, width, wdata);  // Memory written before resp
        end
        @(posedge clk_core);
        dmem_req <= 1'b0;
        d_pending = 1'b0;
    endtask

    task automatic fetch_word(input logic [31:0] addr, input bit timed);
        logic [31:0] exp_word;
        int          waited;
        @(posedge clk_core);
        imem_req  <= 1'b1;
        imem_addr <= addr;
        f_pending = 1'b1;
        fetch_issued++;
        waited = 0;
        do begin
            @(negedge clk_core);
            waited++;
        end while (!imem_resp);
        exp_word = model_read(addr, WIDTH_WORD);
        if (imem_rdata !== exp_word) begin
            report_mismatch("imem_rdata_o", exp_word, imem_rdata);
        end
        if (timed && waited - 1 != WAIT_STATES + 3) begin
            report_mismatch("imem_resp_o latency", 32'(WAIT_STATES + 3), 32'(waited - 1));
        end
        @(posedge clk_core);
        imem_req <= 1'b0;
        f_pending = 1'b0;
    endtask

    task automatic run_data_traffic(input logic [31:0] seed, input int count);
        logic [31:0] r;
        logic [31:0] ctrl;
        logic [31:0] addr;
        mem_width_e  width;
        r = seed;
        for (int i = 0; i < count; i++) begin
            r     = xorshift32(r);
            ctrl  = r;
            width = pick_width(ctrl);
            r     = xorshift32(r);
            addr  = r & WINDOW_MASK;
            if (ctrl[23:21] != 3'b000) begin
                addr = align_addr(addr, width);  // Mostly aligned, a few misaligned
            end
            r = xorshift32(r);
            data_transfer(ctrl[20] ? CMD_WRITE : CMD_READ, width, addr, r, 1'b0);
        end
    endtask

    task automatic run_fetch_traffic(input logic [31:0] seed, input int count);
        logic [31:0] r;
        r = seed;
        for (int i = 0; i < count; i++) begin
            r = xorshift32(r);
            if (r[4]) begin
                @(posedge clk_core);  // Idle gap
            end
            fetch_word(r & WINDOW_MASK & ~32'h3, 1'b0);
        end
    endtask

    // Each resp pulse must belong to an outstanding request
    always @(negedge clk_core) begin
        if (imem_resp) begin
            imem_resp_cnt++;
            if (!f_pending) begin
                $display("Error at %0d ns: imem_resp_o pulsed with no fetch outstanding", $time);
                errors++;
            end
        end
        if (dmem_resp) begin
            dmem_resp_cnt++;
            if (!d_pending) begin
                $display("Error at %0d ns: dmem_resp_o pulsed with no request outstanding", $time);
                errors++;
            end
        end
    end

    always @(posedge clk_core) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data_seed;
        logic [1:0]  offset;
        mem_width_e  width;
        imem_req      = 1'b0;
        imem_addr     = 32'h0;
        dmem_req      = 1'b0;
        dmem_cmd      = CMD_READ;
        dmem_width    = WIDTH_WORD;
        dmem_addr     = 32'h0;
        dmem_wdata    = 32'h0;
        errors        = 0;
        cycle_cnt     = 0;
        imem_resp_cnt = 0;
        dmem_resp_cnt = 0;
        fetch_issued  = 0;
        data_issued   = 0;
        f_pending     = 1'b0;
        d_pending     = 1'b0;
        rng           = 32'h1ba7;
        for (int i = 0; i < MEM_BYTES; i++) begin
            model_mem[i] = 8'h00;
        end

        wait (rst_n === 1'b1);
        @(negedge clk_core);
        if (imem_resp !== 1'b0) begin
            report_mismatch("imem_resp_o", 32'h0, {31'h0, imem_resp});
        end
        if (dmem_resp !== 1'b0) begin
            report_mismatch("dmem_resp_o", 32'h0, {31'h0, dmem_resp});
        end
        if (dmem_err !== 1'b0) begin
            report_mismatch("dmem_err_o", 32'h0, {31'h0, dmem_err});
        end

        // Word writes anywhere in the 32-bit space, then read back
        for (int i = 0; i < WORD_TESTS; i++) begin
            rng  = xorshift32(rng);
            addr = rng & ~32'h3;
            rng  = xorshift32(rng);
            data_transfer(CMD_WRITE, WIDTH_WORD, addr, rng, 1'b1);
            written_q.push_back(addr);
        end
        foreach (written_q[i]) begin
            data_transfer(CMD_READ, WIDTH_WORD, written_q[i], 32'h0, 1'b1);
        end

        // Narrow writes first, reads of any width after
        for (int i = 0; i < 2 * LANE_TESTS; i++) begin
            rng   = xorshift32(rng);
            width = (i < LANE_TESTS) ? (rng[0] ? WIDTH_HALF : WIDTH_BYTE) : pick_width(rng);
            rng   = xorshift32(rng);
            addr  = align_addr(rng & WINDOW_MASK, width);
            rng   = xorshift32(rng);
            data_transfer((i < LANE_TESTS) ? CMD_WRITE : CMD_READ, width, addr, rng, 1'b1);
        end

        for (int i = 0; i < MISALIGNED_TESTS; i++) begin
            rng    = xorshift32(rng);
            width  = rng[0] ? WIDTH_WORD : WIDTH_HALF;
            offset = rng[2:1];
            if (width == WIDTH_HALF) begin
                offset[0] = 1'b1;
            end else if (offset == 2'b00) begin
                offset = 2'b10;
            end
            addr = (rng & WINDOW_MASK & ~32'h3) | {30'h0, offset};
            rng  = xorshift32(rng);
            data_transfer(rng[0] ? CMD_WRITE : CMD_READ, width, addr, rng, 1'b1);
            data_transfer(CMD_READ, WIDTH_WORD, addr & ~32'h3, 32'h0, 1'b1);
        end

        // Fetch the written words through aliased upper address bits
        for (int i = 0; i < FETCH_TESTS; i++) begin
            rng  = xorshift32(rng);
            addr = written_q[i % written_q.size()];
            addr = (rng & ~BYTE_MASK) | (addr & BYTE_MASK);
            fetch_word(addr, 1'b1);
        end

        rng       = xorshift32(rng);
        data_seed = rng;
        rng       = xorshift32(rng);
        fork
            run_data_traffic(data_seed, MIXED_TESTS);
            run_fetch_traffic(rng, MIXED_TESTS);
        join

        repeat (2) @(posedge clk_core);
        if (imem_resp_cnt != fetch_issued) begin
            $display("Fetch port gave %0d responses for %0d requests", imem_resp_cnt,
                     fetch_issued);
            errors++;
        end
        if (dmem_resp_cnt != data_issued) begin
            $display("Data port gave %0d responses for %0d requests", dmem_resp_cnt, data_issued);
            errors++;
        end
        $display("Errors: %0d, data requests: %0d, fetch requests: %0d", errors, data_issued,
                 fetch_issued);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : mem_subsystem_tb

`default_nettype wire

// ==== project.f ====
logic/bus_pkg.sv
logic/fetch_bridge.sv
logic/data_bridge.sv
logic/bus_arbiter.sv
logic/word_memory.sv
logic/mem_subsystem_top.sv
tb/tb_clock_gen.sv
tb/mem_subsystem_asserts.sv
tb/mem_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_subsystem_tb \
    -f project.f \
    -o mem_subsystem_sim

output=$(./obj_dir/mem_subsystem_sim)
echo "$output"

# Exit status follows the search
echo "$output" | grep -q "All tests passed"
